// ==== build.f ====
source/core_regs_pkg.sv
source/stream_pkg.sv
source/stream_if.sv
source/setting_reg.sv
source/core_regs.sv
source/stream_crossbar.sv
source/stream_fifo.sv
source/loopback_engine.sv
source/radio_core.sv
test/radio_core_assertions.sv
test/radio_core_tb.sv

// ==== Makefile ====
TOP = radio_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f build.f
	out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Done: no errors$$'

clean:
	rm -rf obj_dir

// ==== test/radio_core_tb.sv ====
////////////////////
// testbench for the bus clock core covering settings, readback, route
// table and loopback packets with the bound checker module attached
////////////////////
`timescale 1ns/1ps

module radio_core_tb;
  import core_regs_pkg::*;

  // tests take a few hundred cycles even with back-pressure
  localparam int         max_cycles = 2000;
  localparam logic [7:0] dev_addr   = 8'd40;

  logic        bus_clk = 1'b0;
  logic        bus_rst = 1'b1;
  logic [63:0] i_h2s_tdata = '0;
  logic        i_h2s_tlast = 1'b0;
  logic        i_h2s_tvalid = 1'b0;
  logic        o_h2s_tready;
  logic [63:0] o_s2h_tdata;
  logic        o_s2h_tlast;
  logic        o_s2h_tvalid;
  logic        i_s2h_tready = 1'b1;
  logic        i_set_stb = 1'b0;
  logic [31:0] i_set_addr = '0;
  logic [31:0] i_set_data = '0;
  logic [31:0] o_rb_data;
  logic        i_xbar_set_stb = 1'b0;
  logic [31:0] i_xbar_set_addr = '0;
  logic [31:0] i_xbar_set_data = '0;
  logic [31:0] i_xbar_rb_addr = '0;
  logic [31:0] o_xbar_rb_data;
  logic [3:0]  i_tcxo_status = 4'ha;
  logic [1:0]  i_lock_signals = 2'b00;
  logic [1:0]  o_pps_select;
  logic        o_mimo;
  logic        o_codec_arst;
  logic [2:0]  o_tx_bandsel;
  logic [5:0]  o_rx_bandsel_a;
  logic [3:0]  o_rx_bandsel_b;
  logic [3:0]  o_rx_bandsel_c;

  logic [64:0] recv_q [$];
  logic [63:0] sent_q [$];
  logic [31:0] rand_state = 32'd1;
  logic [31:0] bp_state = 32'd1;
  logic        bp_on = 1'b0;
  int          cycles = 0;
  int          check_errors = 0;
  int          errors_before = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  bind radio_core radio_core_assertions u_assert (.*);

  radio_core #(.fifo_depth_log2(5)) u_dut (.i_bus_clk(bus_clk), .i_bus_rst(bus_rst), .*);

  always #2 bus_clk = ~bus_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge bus_clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, run stopped", max_cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // random host back-pressure
  always @(posedge bus_clk) begin
    if (bp_on) begin
      bp_state = lcg_next(bp_state);
      i_s2h_tready <= bp_state[30];
    end else begin
      i_s2h_tready <= 1'b1;
    end
  end

  // returned beats are taken mid-cycle where the handshake has settled
  always @(negedge bus_clk) begin
    if (!bus_rst && o_s2h_tvalid && i_s2h_tready) begin
      recv_q.push_back({o_s2h_tlast, o_s2h_tdata});
    end
  end

  task automatic random_word(output logic [31:0] w);
    rand_state = lcg_next(rand_state);
    w = rand_state;
  endtask

  task automatic write_setting(input logic [10:0] addr, input logic [31:0] data);
    i_set_stb  <= 1'b1;
    i_set_addr <= 32'(addr);
    i_set_data <= data;
    @(posedge bus_clk);
    i_set_stb <= 1'b0;
  endtask

  task automatic select_readback(input logic [4:0] idx);
    write_setting(sr_core_readback, 32'(idx));
    repeat (2) @(posedge bus_clk);
  endtask

  task automatic set_route(input int entry, input logic [1:0] port);
    i_xbar_set_stb  <= 1'b1;
    i_xbar_set_addr <= 32'(entry << 2);
    i_xbar_set_data <= 32'(port);
    @(posedge bus_clk);
    i_xbar_set_stb <= 1'b0;
  endtask

  // header word has a random top half, src 0 and dst device 40 with the route index
  task automatic loop_packet(input logic [1:0] route, input int len);
    logic [31:0] hi;
    logic [31:0] lo;
    logic [63:0] want;
    recv_q.delete();
    sent_q.delete();
    for (int n = 0; n < len; n++) begin
      random_word(hi);
      random_word(lo);
      if (n == 0) lo = {16'h0000, dev_addr, 6'd0, route};
      sent_q.push_back({hi, lo});
      i_h2s_tdata  <= {hi, lo};
      i_h2s_tlast  <= (n == len - 1);
      i_h2s_tvalid <= 1'b1;
      do @(negedge bus_clk); while (!o_h2s_tready);
      @(posedge bus_clk);
    end
    i_h2s_tvalid <= 1'b0;
    while (recv_q.size() == 0 || !recv_q[recv_q.size() - 1][64]) @(posedge bus_clk);
    assert (recv_q.size() == len) else begin
      $display("[ERROR] %0t: %0d words returned, expected %0d", $time, recv_q.size(), len);
      check_errors++;
    end
    for (int n = 0; n < len && n < recv_q.size(); n++) begin
      want = sent_q[n];
      // the engine swaps src and dst in the first word only
      if (n == 0) want = {want[63:32], want[15:0], want[31:16]};
      assert (recv_q[n] == {n == len - 1, want}) else begin
        $display("[ERROR] %0t: word %0d is %h, expected %h", $time, n, recv_q[n],
                 {n == len - 1, want});
        check_errors++;
      end
    end
  endtask

  task automatic end_test(input string name);
    int total;
    repeat (2) @(posedge bus_clk);
    total = check_errors + u_dut.u_assert.fail_count;
    tests_run++;
    if (total == errors_before) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: %0d errors", name, total - errors_before);
      tests_failed++;
    end
    errors_before = total;
  endtask

  initial begin
    logic [31:0] word;
    int          total;
    repeat (5) @(posedge bus_clk);
    bus_rst <= 1'b0;
    @(posedge bus_clk);

    select_readback(rb_core_misc);
    select_readback(rb_core_compat);
    select_readback(5'd9);
    end_test("reset_values");

    random_word(word);
    write_setting(sr_core_test, word);
    select_readback(rb_core_test);
    end_test("test_register");

    random_word(word);
    write_setting(sr_core_misc, word);
    i_lock_signals <= 2'b01;
    repeat (3) @(posedge bus_clk);
    select_readback(rb_core_pll);
    i_lock_signals <= 2'b10;
    repeat (3) @(posedge bus_clk);
    end_test("misc_and_lock");

    set_route(3, 2'd2);
    for (int k = 0; k < 4; k++) begin
      i_xbar_rb_addr <= 32'(k << 2);
      @(posedge bus_clk);
    end
    end_test("route_table");

    loop_packet(2'd1, 4);
    loop_packet(2'd2, 6);
    end_test("loopback");

    bp_on <= 1'b1;
    loop_packet(2'd1, 8);
    loop_packet(2'd2, 12);
    bp_on <= 1'b0;
    end_test("back_pressure");

    total = check_errors + u_dut.u_assert.fail_count;
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== test/radio_core_assertions.sv ====
////////////////////
// concurrent checks bound into the bus clock core on readback values,
// misc outputs, route table readback and host stream stability
////////////////////
`timescale 1ns/1ps

module radio_core_assertions (
  input logic                                i_bus_clk,
  input logic                                i_bus_rst,
  input logic                                i_set_stb,
  input logic [31:0]                         i_set_addr,
  input logic [31:0]                         i_set_data,
  input logic [31:0]                         o_rb_data,
  input logic [3:0]                          i_tcxo_status,
  input logic [1:0]                          i_lock_signals,
  input logic [1:0]                          o_pps_select,
  input logic                                o_mimo,
  input logic                                o_codec_arst,
  input logic [2:0]                          o_tx_bandsel,
  input logic [5:0]                          o_rx_bandsel_a,
  input logic [3:0]                          o_rx_bandsel_b,
  input logic [3:0]                          o_rx_bandsel_c,
  input logic                                i_xbar_set_stb,
  input logic [31:0]                         i_xbar_set_addr,
  input logic [31:0]                         i_xbar_set_data,
  input logic [31:0]                         i_xbar_rb_addr,
  input logic [31:0]                         o_xbar_rb_data,
  input logic [stream_pkg::stream_width-1:0] o_s2h_tdata,
  input logic                                o_s2h_tlast,
  input logic                                o_s2h_tvalid,
  input logic                                i_s2h_tready
);
  import core_regs_pkg::*;

  logic [4:0]  rb_idx;
  logic [31:0] test_val;
  logic [20:0] misc_val;
  logic [1:0]  lock_q1;
  logic [1:0]  lock_q2;
  logic [1:0]  route_q [4];
  logic [31:0] rb_want;
  int          fail_count = 0;

  // reference state followed from the two settings buses
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      rb_idx   <= 5'd0;
      test_val <= 32'd0;
      // pps select 2'b10 and every other field 0
      misc_val <= {19'd0, 2'b10};
      lock_q1  <= 2'b00;
      lock_q2  <= 2'b00;
      route_q  <= '{2'd0, 2'd1, 2'd2, 2'd0};
    end else begin
      lock_q1 <= i_lock_signals;
      lock_q2 <= lock_q1;
      if (i_set_stb && (i_set_addr == 32'(sr_core_readback))) begin
        rb_idx <= i_set_data[4:0];
      end
      if (i_set_stb && (i_set_addr == 32'(sr_core_test))) begin
        test_val <= i_set_data;
      end
      if (i_set_stb && (i_set_addr == 32'(sr_core_misc))) begin
        misc_val <= i_set_data[20:0];
      end
      if (i_xbar_set_stb) begin
        route_q[i_xbar_set_addr[3:2]] <= i_xbar_set_data[1:0];
      end
    end
  end

  always_comb begin
    case (rb_idx)
      rb_core_test:   rb_want = test_val;
      rb_core_misc:   rb_want = {26'd0, i_tcxo_status, misc_val[1:0]};
      rb_core_compat: rb_want = compat_word;
      rb_core_pll:    rb_want = {30'd0, lock_q2};
      default:        rb_want = 32'hdead_beef;
    endcase
  end

  ////////////////////
  // checks
  ////////////////////
  a_readback: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
    o_rb_data == rb_want)
  else begin
    $error("[ERROR] %0t readback %h, expected %h", $time, o_rb_data, rb_want);
    fail_count++;
  end

  a_misc: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
    {o_rx_bandsel_c, o_rx_bandsel_b, o_rx_bandsel_a, o_tx_bandsel,
     o_codec_arst, o_mimo, o_pps_select} == misc_val)
  else begin
    $error("[ERROR] %0t misc outputs differ from %h", $time, misc_val);
    fail_count++;
  end

  a_route: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
    o_xbar_rb_data == {30'd0, route_q[i_xbar_rb_addr[3:2]]})
  else begin
    $error("[ERROR] %0t route readback %h is wrong", $time, o_xbar_rb_data);
    fail_count++;
  end

  // a stalled beat must wait unchanged
  a_hold: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
    o_s2h_tvalid && !i_s2h_tready |=>
      o_s2h_tvalid && $stable(o_s2h_tdata) && $stable(o_s2h_tlast))
  else begin
    $error("[ERROR] %0t host output changed while stalled", $time);
    fail_count++;
  end

endmodule

// ==== source/radio_core.sv ====
////////////////////
// top of the bus clock core with the global registers and the packet
// router, its host port, loopback engine and buffered loopback engine
////////////////////
`timescale 1ns/1ps

module radio_core #(
  parameter int fifo_depth_log2 = 5
) (
  input  logic                                i_bus_clk,
  input  logic                                i_bus_rst,
  // host stream in
  input  logic [stream_pkg::stream_width-1:0] i_h2s_tdata,
  input  logic                                i_h2s_tlast,
  input  logic                                i_h2s_tvalid,
  output logic                                o_h2s_tready,
  // host stream out
  output logic [stream_pkg::stream_width-1:0] o_s2h_tdata,
  output logic                                o_s2h_tlast,
  output logic                                o_s2h_tvalid,
  input  logic                                i_s2h_tready,
  // global settings bus
  input  logic                                i_set_stb,
  input  logic [31:0]                         i_set_addr,
  input  logic [31:0]                         i_set_data,
  output logic [31:0]                         o_rb_data,
  // crossbar settings bus
  input  logic                                i_xbar_set_stb,
  input  logic [31:0]                         i_xbar_set_addr,
  input  logic [31:0]                         i_xbar_set_data,
  input  logic [31:0]                         i_xbar_rb_addr,
  output logic [31:0]                         o_xbar_rb_data,
  // board status and controls
  input  logic [3:0]                          i_tcxo_status,
  input  logic [1:0]                          i_lock_signals,
  output logic [1:0]                          o_pps_select,
  output logic                                o_mimo,
  output logic                                o_codec_arst,
  output logic [2:0]                          o_tx_bandsel,
  output logic [5:0]                          o_rx_bandsel_a,
  output logic [3:0]                          o_rx_bandsel_b,
  output logic [3:0]                          o_rx_bandsel_c
);
  import stream_pkg::*;

  logic [7:0] local_addr;

  // port 0 is the host, port 1 engine 0 and port 2 the buffered engine 1
  stream_if xb_in  [num_ports] ();
  stream_if xb_out [num_ports] ();
  stream_if buf_out ();

  assign xb_in[0].tdata  = i_h2s_tdata;
  assign xb_in[0].tlast  = i_h2s_tlast;
  assign xb_in[0].tvalid = i_h2s_tvalid;
  assign o_h2s_tready    = xb_in[0].tready;

  assign o_s2h_tdata      = xb_out[0].tdata;
  assign o_s2h_tlast      = xb_out[0].tlast;
  assign o_s2h_tvalid     = xb_out[0].tvalid;
  assign xb_out[0].tready = i_s2h_tready;

  core_regs u_core_regs (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_tcxo_status(i_tcxo_status), .i_lock_signals(i_lock_signals),
    .o_rb_data(o_rb_data), .o_local_addr(local_addr),
    .o_pps_select(o_pps_select), .o_mimo(o_mimo), .o_codec_arst(o_codec_arst),
    .o_tx_bandsel(o_tx_bandsel), .o_rx_bandsel_a(o_rx_bandsel_a),
    .o_rx_bandsel_b(o_rx_bandsel_b), .o_rx_bandsel_c(o_rx_bandsel_c)
  );

  stream_crossbar u_xbar (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_local_addr(local_addr),
    .i_xbar_set_stb(i_xbar_set_stb), .i_xbar_set_addr(i_xbar_set_addr),
    .i_xbar_set_data(i_xbar_set_data), .i_xbar_rb_addr(i_xbar_rb_addr),
    .o_xbar_rb_data(o_xbar_rb_data), .in(xb_in), .out(xb_out)
  );

  loopback_engine u_ce0 (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .in(xb_out[1]), .out(xb_in[1])
  );

  stream_fifo #(.fifo_depth_log2(fifo_depth_log2)) u_pkt_buf (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .in(xb_out[2]), .out(buf_out)
  );

  loopback_engine u_ce1 (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .in(buf_out), .out(xb_in[2])
  );

endmodule

// ==== source/loopback_engine.sv ====
////////////////////
// stand-in compute engine, sends every packet back to its source
////////////////////
`timescale 1ns/1ps

module loopback_engine (
  input  logic  i_bus_clk,
  input  logic  i_bus_rst,
  stream_if.snk in,
  stream_if.src out
);
  import stream_pkg::*;

  logic                    first;
  logic [stream_width-1:0] swapped;

  // header word with source and destination exchanged
  always_comb begin
    swapped = in.tdata;
    swapped[dst_lsb +: addr_width] = in.tdata[src_lsb +: addr_width];
    swapped[src_lsb +: addr_width] = in.tdata[dst_lsb +: addr_width];
  end

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      first <= 1'b1;
    end else if (in.tvalid && out.tready) begin
      first <= in.tlast;
    end
  end

  assign out.tdata  = first ? swapped : in.tdata;
  assign out.tlast  = in.tlast;
  assign out.tvalid = in.tvalid;
  assign in.tready  = out.tready;

endmodule

// ==== source/stream_fifo.sv ====
////////////////////
// synchronous packet buffer, circular store of data and tlast
////////////////////
`timescale 1ns/1ps

module stream_fifo #(
  parameter int fifo_depth_log2 = 5
) (
  input  logic  i_bus_clk,
  input  logic  i_bus_rst,
  stream_if.snk in,
  stream_if.src out
);
  import stream_pkg::*;

  localparam int depth = 2 ** fifo_depth_log2;

  logic [stream_width:0]      mem [depth];
  logic [fifo_depth_log2:0]   wr_ptr;
  logic [fifo_depth_log2:0]   rd_ptr;
  logic                       full;
  logic                       empty;

  // extra pointer bit tells full from empty
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[fifo_depth_log2] != rd_ptr[fifo_depth_log2]) &&
                 (wr_ptr[fifo_depth_log2-1:0] == rd_ptr[fifo_depth_log2-1:0]);

  assign in.tready  = !full;
  assign out.tvalid = !empty;
  assign {out.tlast, out.tdata} = mem[rd_ptr[fifo_depth_log2-1:0]];

  always_ff @(posedge i_bus_clk) begin
    if (in.tvalid && !full) begin
      mem[wr_ptr[fifo_depth_log2-1:0]] <= {in.tlast, in.tdata};
    end
  end

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (in.tvalid && !full) wr_ptr <= wr_ptr + 1'b1;
      if (out.tready && !empty) rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

// ==== source/stream_crossbar.sv ====
////////////////////
// packet router between the stream ports, each output picks one input
// round-robin and keeps it until the end of the packet
////////////////////
`timescale 1ns/1ps

module stream_crossbar (
  input  logic        i_bus_clk,
  input  logic        i_bus_rst,
  input  logic [7:0]  i_local_addr,
  input  logic        i_xbar_set_stb,
  input  logic [31:0] i_xbar_set_addr,
  input  logic [31:0] i_xbar_set_data,
  input  logic [31:0] i_xbar_rb_addr,
  output logic [31:0] o_xbar_rb_data,
  stream_if.snk       in  [stream_pkg::num_ports],
  stream_if.src       out [stream_pkg::num_ports]
);
  import stream_pkg::*;

  logic [stream_width-1:0] in_tdata  [num_ports];
  logic                    in_tlast  [num_ports];
  logic                    in_tvalid [num_ports];
  logic [num_ports-1:0]    in_tready;
  logic                    in_first  [num_ports];
  port_t                   in_dest   [num_ports];
  logic                    out_tready [num_ports];
  logic                    out_busy  [num_ports];
  port_t                   out_sel   [num_ports];
  port_t                   out_last  [num_ports];
  port_t                   route_tbl [4];

  ////////////////////
  // route table
  ////////////////////
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      for (int k = 0; k < 4; k++) begin
        route_tbl[k] <= (k < num_ports) ? port_t'(k) : port_t'(0);
      end
    end else if (i_xbar_set_stb) begin
      route_tbl[i_xbar_set_addr[3:2]] <= i_xbar_set_data[1:0];
    end
  end

  assign o_xbar_rb_data = {30'd0, route_tbl[i_xbar_rb_addr[3:2]]};

  ////////////////////
  // input side
  ////////////////////
  for (genvar i = 0; i < num_ports; i++) begin : g_in
    assign in_tdata[i]  = in[i].tdata;
    assign in_tlast[i]  = in[i].tlast;
    assign in_tvalid[i] = in[i].tvalid;
    assign in[i].tready = in_tready[i];

    // foreign device address goes to the host
    assign in_dest[i] = (in_tdata[i][dst_lsb+8 +: 8] != i_local_addr) ? port_t'(0)
                      : route_tbl[in_tdata[i][dst_lsb +: 2]];

    always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
        in_first[i] <= 1'b1;
      end else if (in_tvalid[i] && in_tready[i]) begin
        in_first[i] <= in_tlast[i];
      end
    end
  end

  // an input moves only when the output holding it takes the beat
  always_comb begin
    for (int i = 0; i < num_ports; i++) begin
      in_tready[i] = 1'b0;
      for (int o = 0; o < num_ports; o++) begin
        if (out_busy[o] && (out_sel[o] == port_t'(i)) && out_tready[o]) begin
          in_tready[i] = 1'b1;
        end
      end
    end
  end

  ////////////////////
  // output side
  ////////////////////
  for (genvar o = 0; o < num_ports; o++) begin : g_out
    logic [num_ports-1:0] req;
    port_t                pick;
    logic                 pick_vld;

    for (genvar i = 0; i < num_ports; i++) begin : g_req
      assign req[i] = in_tvalid[i] && in_first[i] && (in_dest[i] == port_t'(o));
    end

    // scan downward so the port right after the last grant wins
    always_comb begin
      pick     = out_last[o];
      pick_vld = 1'b0;
      for (int k = num_ports; k >= 1; k--) begin
        if (req[(int'(out_last[o]) + k) % num_ports]) begin
          pick     = port_t'((int'(out_last[o]) + k) % num_ports);
          pick_vld = 1'b1;
        end
      end
    end

    always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
        out_busy[o] <= 1'b0;
        out_sel[o]  <= port_t'(0);
        out_last[o] <= port_t'(num_ports - 1);
      end else if (!out_busy[o]) begin
        if (pick_vld) begin
          out_busy[o] <= 1'b1;
          out_sel[o]  <= pick;
          out_last[o] <= pick;
        end
      end else if (in_tvalid[out_sel[o]] && out_tready[o] && in_tlast[out_sel[o]]) begin
        out_busy[o] <= 1'b0;
      end
    end

    assign out[o].tdata  = in_tdata[out_sel[o]];
    assign out[o].tlast  = in_tlast[out_sel[o]];
    assign out[o].tvalid = out_busy[o] && in_tvalid[out_sel[o]];
    assign out_tready[o] = out[o].tready;
  end

endmodule

// ==== source/core_regs.sv ====
////////////////////
// global registers of the bus clock core: misc controls, pll lock
// status and the readback mux for the settings bus
////////////////////
`timescale 1ns/1ps

module core_regs (
  input  logic        i_bus_clk,
  input  logic        i_bus_rst,
  input  logic        i_set_stb,
  input  logic [31:0] i_set_addr,
  input  logic [31:0] i_set_data,
  input  logic [3:0]  i_tcxo_status,
  input  logic [1:0]  i_lock_signals,
  output logic [31:0] o_rb_data,
  output logic [7:0]  o_local_addr,
  output logic [1:0]  o_pps_select,
  output logic        o_mimo,
  output logic        o_codec_arst,
  output logic [2:0]  o_tx_bandsel,
  output logic [5:0]  o_rx_bandsel_a,
  output logic [3:0]  o_rx_bandsel_b,
  output logic [3:0]  o_rx_bandsel_c
);
  import core_regs_pkg::*;

  logic [4:0]            rb_addr;
  logic [31:0]           rb_test;
  logic [misc_width-1:0] misc_out;
  logic [1:0]            lock_meta;
  logic [1:0]            lock_sync;

  // lock inputs come from the codec, two flops before use
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      lock_meta <= 2'b00;
      lock_sync <= 2'b00;
    end else begin
      lock_meta <= i_lock_signals;
      lock_sync <= lock_meta;
    end
  end

  ////////////////////
  // settings registers
  ////////////////////
  setting_reg #(.my_addr(sr_core_readback), .width(5), .at_reset(5'd0)) u_sr_readback (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_strobe(i_set_stb),
    .i_addr(i_set_addr), .i_data(i_set_data), .o_value(rb_addr)
  );

  setting_reg #(.my_addr(sr_core_test), .width(32), .at_reset(32'd0)) u_sr_test (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_strobe(i_set_stb),
    .i_addr(i_set_addr), .i_data(i_set_data), .o_value(rb_test)
  );

  setting_reg #(
    .my_addr(sr_core_misc), .width(misc_width), .at_reset(misc_reset[misc_width-1:0])
  ) u_sr_misc (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_strobe(i_set_stb),
    .i_addr(i_set_addr), .i_data(i_set_data), .o_value(misc_out)
  );

  setting_reg #(.my_addr(sr_core_xb_local), .width(8), .at_reset(xb_local_reset)) u_sr_xb_local (
    .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst), .i_strobe(i_set_stb),
    .i_addr(i_set_addr), .i_data(i_set_data), .o_value(o_local_addr)
  );

  // misc fields to the board controls
  assign o_pps_select   = misc_out[misc_pps_lsb +: 2];
  assign o_mimo         = misc_out[misc_mimo_bit];
  assign o_codec_arst   = misc_out[misc_codec_bit];
  assign o_tx_bandsel   = misc_out[misc_tx_band_lsb +: 3];
  assign o_rx_bandsel_a = misc_out[misc_rx_a_lsb +: 6];
  assign o_rx_bandsel_b = misc_out[misc_rx_b_lsb +: 4];
  assign o_rx_bandsel_c = misc_out[misc_rx_c_lsb +: 4];

  ////////////////////
  // readback mux
  ////////////////////
  always_comb begin
    case (rb_addr)
      rb_core_test:   o_rb_data = rb_test;
      rb_core_misc:   o_rb_data = {26'd0, i_tcxo_status, o_pps_select};
      rb_core_compat: o_rb_data = compat_word;
      rb_core_pll:    o_rb_data = {30'd0, lock_sync};
      default:        o_rb_data = rb_default;
    endcase
  end

endmodule

// ==== source/setting_reg.sv ====
////////////////////
// single settings bus register, loads on a strobe at its own address
////////////////////
`timescale 1ns/1ps

module setting_reg #(
  parameter logic [10:0]      my_addr  = 11'd0,
  parameter int               width    = 32,
  parameter logic [width-1:0] at_reset = '0
) (
  input  logic             i_bus_clk,
  input  logic             i_bus_rst,
  input  logic             i_strobe,
  input  logic [31:0]      i_addr,
  input  logic [31:0]      i_data,
  output logic [width-1:0] o_value
);

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      o_value <= at_reset;
    end else if (i_strobe && (i_addr == 32'(my_addr))) begin
      o_value <= i_data[width-1:0];
    end
  end

endmodule

// ==== source/stream_if.sv ====
////////////////////
// valid/ready packet stream, one beat moves when tvalid and tready are high
////////////////////
`timescale 1ns/1ps

interface stream_if;
  import stream_pkg::*;

  logic [stream_width-1:0] tdata;
  logic                    tlast;
  logic                    tvalid;
  logic                    tready;

  modport src (output tdata, output tlast, output tvalid, input tready);
  modport snk (input tdata, input tlast, input tvalid, output tready);

endinterface

// ==== source/stream_pkg.sv ====
////////////////////
// packet stream constants shared by the router and the engines
////////////////////
package stream_pkg;

  localparam int stream_width = 64;
  localparam int num_ports    = 3;

  typedef logic [1:0] port_t;

  // header fields in the first word of a packet
  localparam int addr_width = 16;
  localparam int dst_lsb    = 0;
  localparam int src_lsb    = 16;

endpackage

// ==== source/core_regs_pkg.sv ====
////////////////////
// global register block constants: settings offsets, readback indices
// and bit positions of the misc control fields
////////////////////
package core_regs_pkg;

  // settings bus offsets
  localparam logic [10:0] sr_core_readback = 11'd0;
  localparam logic [10:0] sr_core_misc     = 11'd4;
  localparam logic [10:0] sr_core_test     = 11'd28;
  localparam logic [10:0] sr_core_xb_local = 11'd32;

  // readback mux indices
  localparam logic [4:0] rb_core_misc   = 5'd1;
  localparam logic [4:0] rb_core_compat = 5'd2;
  localparam logic [4:0] rb_core_pll    = 5'd4;
  localparam logic [4:0] rb_core_test   = 5'd24;

  localparam logic [31:0] compat_word    = 32'hac00_0c00;
  // internal pps source selected out of reset
  localparam logic [31:0] misc_reset     = 32'h0000_0002;
  localparam logic [7:0]  xb_local_reset = 8'd40;
  localparam logic [31:0] rb_default     = 32'hdead_beef;

  // misc register field positions
  localparam int misc_pps_lsb     = 0;
  localparam int misc_mimo_bit    = 2;
  localparam int misc_codec_bit   = 3;
  localparam int misc_tx_band_lsb = 4;
  localparam int misc_rx_a_lsb    = 7;
  localparam int misc_rx_b_lsb    = 13;
  localparam int misc_rx_c_lsb    = 17;
  localparam int misc_width       = 21;

endpackage
